// File: src/lu_pkg.sv
package lu_pkg;

    // --------------------------------------------------
    // Operation code
    // --------------------------------------------------

    // Width of the operation field
    localparam int OP_W = 4;

    typedef logic [OP_W-1:0] op_t;

    // Shifts
    // Bit 0 set means shift right, bit 1 set means arithmetic fill
    localparam op_t OP_SLL  = 4'b0000;
    localparam op_t OP_SRL  = 4'b0001;
    localparam op_t OP_SRA  = 4'b0011;

    // Bitwise words
    localparam op_t OP_XOR  = 4'b0010;
    localparam op_t OP_OR   = 4'b0110;
    localparam op_t OP_AND  = 4'b0111;

    // Set-less-than, result is 0 or 1
    localparam op_t OP_SLT  = 4'b0100;
    localparam op_t OP_SLTU = 4'b0101;

    // --------------------------------------------------
    // Branch comparisons
    // --------------------------------------------------

    // Same 0 or 1 result as the set-less-than codes
    localparam op_t OP_EQ   = 4'b1000;
    localparam op_t OP_NE   = 4'b1001;
    localparam op_t OP_LT   = 4'b1010;
    localparam op_t OP_GE   = 4'b1011;
    localparam op_t OP_LTU  = 4'b1100;
    localparam op_t OP_GEU  = 4'b1101;

    // Codes 1110 and 1111 unused
    // Unit passes operand_a through for them

endpackage

// File: src/lu_shifter.sv
`timescale 1ns/100ps

module lu_shifter #(
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic [WIDTH-1:0]         operand_a,
    input  logic [$clog2(WIDTH)-1:0] shift_amount,
    input  lu_pkg::op_t              operation,
    output logic [WIDTH-1:0]         shift_result
);

    // Number of shifter stages
    localparam int SHW = $clog2(WIDTH);

    // Decoded shift controls
    logic right_dir;
    logic arith;
    logic fill_bit;

    // Stage 0 is the (possibly reversed) input
    logic [WIDTH-1:0] pre_word;
    logic [WIDTH-1:0] stage [SHW+1];
    logic [WIDTH-1:0] post_word;

    // Mirror a word end for end
    function automatic logic [WIDTH-1:0] bit_reverse(input logic [WIDTH-1:0] w);
        logic [WIDTH-1:0] r;
        for (int j = 0; j < WIDTH; j++) begin
            r[j] = w[WIDTH-1-j];
        end
        return r;
    endfunction

    // --------------------------------------------------
    // Direction and fill
    // --------------------------------------------------

    assign right_dir = operation[0];
    assign arith     = operation[1];

    // Sign fill only for SRA
    // Left shifts are run as right shifts on the mirrored word, so zero fill
    assign fill_bit = arith & right_dir & operand_a[WIDTH-1];

    // Left shift enters mirrored
    assign pre_word = right_dir ? operand_a : bit_reverse(operand_a);
    assign stage[0] = pre_word;

    // --------------------------------------------------
    // Log-depth right shift
    // --------------------------------------------------

    // Stage s moves the word by 2**s when its amount bit is set
    for (genvar s = 0; s < SHW; s++) begin : g_stage
        localparam int STEP = 1 << s;
        assign stage[s+1] = shift_amount[s]
                          ? {{STEP{fill_bit}}, stage[s][WIDTH-1:STEP]}
                          : stage[s];
    end

    assign post_word = stage[SHW];

    // Undo the mirror for a left shift
    assign shift_result = right_dir ? post_word : bit_reverse(post_word);

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Zero amount leaves the word as is, both mirror paths included
    a_zero_shift: assert property (
        @(posedge clk) (shift_amount == '0) |-> (shift_result == operand_a)
    );

endmodule

// File: src/lu_bitwise_compare.sv
`timescale 1ns/100ps

module lu_bitwise_compare #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] operand_a,
    input  logic [WIDTH-1:0] operand_b,
    output logic [WIDTH-1:0] xor_word,
    output logic [WIDTH-1:0] or_word,
    output logic [WIDTH-1:0] and_word,
    output logic             eq,
    output logic             lt_signed,
    output logic             lt_unsigned
);

    // Ripple borrow chain, borrow[0] is the borrow in
    logic [WIDTH:0]   borrow;
    // Difference a - b, only its top bit matters here
    logic [WIDTH-1:0] diff;

    // Sign bits
    logic sign_a;
    logic sign_b;
    logic sign_diff;

    // --------------------------------------------------
    // Bitwise words
    // --------------------------------------------------

    assign xor_word = operand_a ^ operand_b;
    assign or_word  = operand_a | operand_b;
    assign and_word = operand_a & operand_b;

    // Equal when no bit differs
    assign eq = ~|xor_word;

    // --------------------------------------------------
    // Borrow subtractor
    // --------------------------------------------------

    always_comb begin
        borrow[0] = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            diff[i]     = operand_a[i] ^ operand_b[i] ^ borrow[i];
            // Borrow out when a bit is short of b plus borrow in
            borrow[i+1] = (~operand_a[i] & operand_b[i])
                        | (~operand_a[i] & borrow[i])
                        | (operand_b[i] & borrow[i]);
        end
    end

    // Final borrow means a below b unsigned
    assign lt_unsigned = borrow[WIDTH];

    // --------------------------------------------------
    // Signed less-than
    // --------------------------------------------------

    assign sign_a    = operand_a[WIDTH-1];
    assign sign_b    = operand_b[WIDTH-1];
    assign sign_diff = sign_a ^ sign_b;

    // Mixed signs decide on sign_a alone
    // Same signs cannot overflow, so the difference sign decides
    assign lt_signed = sign_diff ? sign_a : diff[WIDTH-1];

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Subtractor and XOR path must agree on equality
    a_eq_excl_lt: assert property (
        @(posedge clk) !(eq && lt_unsigned)
    );

endmodule

// File: src/lu_result_select.sv
`timescale 1ns/100ps

module lu_result_select #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             req,
    input  lu_pkg::op_t      operation,
    input  logic [WIDTH-1:0] operand_a,
    input  logic [WIDTH-1:0] shift_result,
    input  logic [WIDTH-1:0] xor_word,
    input  logic [WIDTH-1:0] or_word,
    input  logic [WIDTH-1:0] and_word,
    input  logic             eq,
    input  logic             lt_signed,
    input  logic             lt_unsigned,
    output logic             ack,
    output logic [WIDTH-1:0] result
);

    // Zero bits above a flag result
    localparam int PAD = WIDTH - 1;

    logic [WIDTH-1:0] next_result;
    // New request seen while idle
    logic             load;

    // --------------------------------------------------
    // Operation decode
    // --------------------------------------------------

    always_comb begin
        case (operation)
            // Shift unit output
            lu_pkg::OP_SLL,
            lu_pkg::OP_SRL,
            lu_pkg::OP_SRA:  next_result = shift_result;
            // Bitwise words
            lu_pkg::OP_XOR:  next_result = xor_word;
            lu_pkg::OP_OR:   next_result = or_word;
            lu_pkg::OP_AND:  next_result = and_word;
            // Zero-extended flags
            lu_pkg::OP_SLT,
            lu_pkg::OP_LT:   next_result = {{PAD{1'b0}}, lt_signed};
            lu_pkg::OP_SLTU,
            lu_pkg::OP_LTU:  next_result = {{PAD{1'b0}}, lt_unsigned};
            lu_pkg::OP_EQ:   next_result = {{PAD{1'b0}}, eq};
            // Inverted flags
            lu_pkg::OP_NE:   next_result = {{PAD{1'b0}}, ~eq};
            lu_pkg::OP_GE:   next_result = {{PAD{1'b0}}, ~lt_signed};
            lu_pkg::OP_GEU:  next_result = {{PAD{1'b0}}, ~lt_unsigned};
            // Undefined codes pass operand_a through
            default:         next_result = operand_a;
        endcase
    end

    // --------------------------------------------------
    // Four-phase handshake
    // --------------------------------------------------

    assign load = req && !ack;

    // ack up on a fresh req, down once req is seen low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else if (load) begin
            ack <= 1'b1;
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

    // Capture on the same edge that raises ack
    // Held while req stays high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (load) begin
            result <= next_result;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Each ack rise answers a sampled req
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req)
    );

    // Requester starts a new req only after the last ack is gone
    a_req_while_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(req) |-> !ack
    );

endmodule

// File: src/lu_top.sv
`timescale 1ns/100ps

module lu_top #(
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req,
    input  logic [WIDTH-1:0]         operand_a,
    input  logic [WIDTH-1:0]         operand_b,
    input  lu_pkg::op_t              operation,
    input  logic [$clog2(WIDTH)-1:0] shift_amount,
    output logic                     ack,
    output logic [WIDTH-1:0]         result
);

    // Shifter output
    logic [WIDTH-1:0] shift_result;

    // Bitwise words and compare flags
    logic [WIDTH-1:0] xor_word;
    logic [WIDTH-1:0] or_word;
    logic [WIDTH-1:0] and_word;
    logic             eq;
    logic             lt_signed;
    logic             lt_unsigned;

    // --------------------------------------------------
    // Parallel datapath
    // --------------------------------------------------

    lu_shifter #(
        .WIDTH(WIDTH)
    ) lu_shifter_i (
        .clk         (clk),
        .operand_a   (operand_a),
        .shift_amount(shift_amount),
        .operation   (operation),
        .shift_result(shift_result)
    );

    lu_bitwise_compare #(
        .WIDTH(WIDTH)
    ) lu_bitwise_compare_i (
        .clk        (clk),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .xor_word   (xor_word),
        .or_word    (or_word),
        .and_word   (and_word),
        .eq         (eq),
        .lt_signed  (lt_signed),
        .lt_unsigned(lt_unsigned)
    );

    // --------------------------------------------------
    // Select, register and handshake
    // --------------------------------------------------

    lu_result_select #(
        .WIDTH(WIDTH)
    ) lu_result_select_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .operation   (operation),
        .operand_a   (operand_a),
        .shift_result(shift_result),
        .xor_word    (xor_word),
        .or_word     (or_word),
        .and_word    (and_word),
        .eq          (eq),
        .lt_signed   (lt_signed),
        .lt_unsigned (lt_unsigned),
        .ack         (ack),
        .result      (result)
    );

endmodule

// File: dv/lu_model.svh
`ifndef LU_MODEL_SVH
`define LU_MODEL_SVH

// --------------------------------------------------
// Expected result for one operation, 32-bit datapath
// --------------------------------------------------

function automatic logic [31:0] lu_model(
    input lu_pkg::op_t op,
    input logic [31:0] a,
    input logic [31:0] b,
    input logic [4:0]  sh
);
    logic [31:0] r;
    case (op)
        // Shifts by plain operators
        lu_pkg::OP_SLL:  r = a << sh;
        lu_pkg::OP_SRL:  r = a >> sh;
        lu_pkg::OP_SRA:  r = $signed(a) >>> sh;
        // Bitwise
        lu_pkg::OP_XOR:  r = a ^ b;
        lu_pkg::OP_OR:   r = a | b;
        lu_pkg::OP_AND:  r = a & b;
        // Signed and unsigned less-than
        lu_pkg::OP_SLT,
        lu_pkg::OP_LT:   r = {31'd0, $signed(a) < $signed(b)};
        lu_pkg::OP_SLTU,
        lu_pkg::OP_LTU:  r = {31'd0, a < b};
        // Equality and the inverted forms
        lu_pkg::OP_EQ:   r = {31'd0, a == b};
        lu_pkg::OP_NE:   r = {31'd0, a != b};
        lu_pkg::OP_GE:   r = {31'd0, $signed(a) >= $signed(b)};
        lu_pkg::OP_GEU:  r = {31'd0, a >= b};
        // Undefined codes echo operand a
        default:         r = a;
    endcase
    return r;
endfunction

`endif

// File: dv/lu_tb.sv
`timescale 1ns/100ps

module lu_tb;

    `include "lu_model.svh"

    // Cycles any single wait may take
    localparam int TIMEOUT = 20;

    logic                clk;
    logic                arst_n;
    logic                req;
    logic [31:0]         operand_a;
    logic [31:0]         operand_b;
    lu_pkg::op_t         operation;
    logic [4:0]          shift_amount;
    logic                ack;
    logic [31:0]         result;

    int check_count;
    int mismatch_count;
    int other_count;

    // Operation pools per test group
    lu_pkg::op_t bit_ops [3];
    lu_pkg::op_t shift_ops [3];
    lu_pkg::op_t cmp_ops [8];

    lu_top #(
        .WIDTH(32)
    ) lu_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .operation   (operation),
        .shift_amount(shift_amount),
        .ack         (ack),
        .result      (result)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // --------------------------------------------------
    // One full four-phase transfer with checks
    // --------------------------------------------------

    task automatic run_op(input string name, input lu_pkg::op_t op,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] sh);
        logic [31:0] expected;
        logic [31:0] rnd;
        int          wait_cnt;
        int          extra;
        expected = lu_model(op, a, b, sh);
        extra    = $urandom_range(3, 0);
        @(negedge clk);
        operation    = op;
        operand_a    = a;
        operand_b    = b;
        shift_amount = sh;
        req          = 1'b1;
        // Wait for ack
        wait_cnt = 0;
        while (!ack && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!ack) begin
            $display("ERROR %s: no ack within %0d cycles of req", name, TIMEOUT);
            other_count++;
            req = 1'b0;
            return;
        end
        if (wait_cnt > 1) begin
            $display("ERROR %s: ack came %0d cycles after req", name, wait_cnt);
            other_count++;
        end
        check_count++;
        if (result !== expected) begin
            $display("MISMATCH %s op=%b: expected %h actual %h", name, op, expected, result);
            mismatch_count++;
        end
        // Back-pressure holds ack and result while the inputs move on
        repeat (extra) begin
            rnd          = $urandom();
            operation    = rnd[3:0];
            shift_amount = rnd[8:4];
            operand_a    = $urandom();
            operand_b    = $urandom();
            @(negedge clk);
            check_count++;
            if (!ack) begin
                $display("ERROR %s: ack dropped while req still high", name);
                other_count++;
            end
            if (result !== expected) begin
                $display("MISMATCH %s hold: expected %h actual %h", name, expected, result);
                mismatch_count++;
            end
        end
        req = 1'b0;
        // Wait for ack to fall
        wait_cnt = 0;
        while (ack && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (ack) begin
            $display("ERROR %s: ack still high %0d cycles after req dropped", name, TIMEOUT);
            other_count++;
        end else if (wait_cnt > 1) begin
            $display("ERROR %s: ack fell %0d cycles after req dropped", name, wait_cnt);
            other_count++;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] w;
        logic [4:0]  sh;
        clk            = 1'b0;
        arst_n         = 1'b0;
        req            = 1'b0;
        operand_a      = '0;
        operand_b      = '0;
        operation      = lu_pkg::OP_SLL;
        shift_amount   = '0;
        check_count    = 0;
        mismatch_count = 0;
        other_count    = 0;
        bit_ops   = '{lu_pkg::OP_XOR, lu_pkg::OP_OR, lu_pkg::OP_AND};
        shift_ops = '{lu_pkg::OP_SLL, lu_pkg::OP_SRL, lu_pkg::OP_SRA};
        cmp_ops   = '{lu_pkg::OP_SLT, lu_pkg::OP_SLTU, lu_pkg::OP_EQ, lu_pkg::OP_NE,
                      lu_pkg::OP_LT, lu_pkg::OP_GE, lu_pkg::OP_LTU, lu_pkg::OP_GEU};
        void'($urandom(32'hd488b1eb));

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Idle state after reset
        @(negedge clk);
        check_count++;
        if (ack !== 1'b0) begin
            $display("MISMATCH reset ack: expected %b actual %b", 1'b0, ack);
            mismatch_count++;
        end
        if (result !== 32'd0) begin
            $display("MISMATCH reset result: expected %h actual %h", 32'd0, result);
            mismatch_count++;
        end

        // Bitwise group
        for (int i = 0; i < 200; i++) begin
            run_op("bitwise", bit_ops[$urandom_range(2, 0)], $urandom(), $urandom(), 5'd0);
        end

        // Shift group with the sign bit set on every other operand
        // Edge amounts 0 and 31 mixed in
        for (int i = 0; i < 200; i++) begin
            a = $urandom();
            a[31] = (i % 2 == 0);
            w = $urandom();
            case (i % 4)
                0:       sh = 5'd0;
                1:       sh = 5'd31;
                default: sh = w[4:0];
            endcase
            run_op("shift", shift_ops[$urandom_range(2, 0)], a, $urandom(), sh);
        end

        // Compare group with equal or straddling operands on every other op
        for (int i = 0; i < 300; i++) begin
            a = $urandom();
            b = $urandom();
            if (i % 2 == 0) begin
                w = $urandom();
                if (w[0]) begin
                    b = a;
                end else begin
                    a[31] = w[1];
                    b[31] = ~w[1];
                end
            end
            run_op("compare", cmp_ops[$urandom_range(7, 0)], a, b, 5'd0);
        end

        // Unused codes echo operand_a
        for (int i = 0; i < 20; i++) begin
            run_op("undefined", (i % 2 == 0) ? 4'b1110 : 4'b1111, $urandom(), $urandom(), 5'd0);
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+dv
src/lu_pkg.sv
src/lu_shifter.sv
src/lu_bitwise_compare.sv
src/lu_result_select.sv
src/lu_top.sv
dv/lu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the logic unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f sources.f --top-module lu_tb \
    -Mdir obj_dir -o lu_sim \
    && ./obj_dir/lu_sim 2>&1 | tee "$LOG" \
    || { echo "Build or run error"; exit 1; }

# Result is decided from the log
grep -q "Some tests failed" "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0
